/* logic/aes_bridge_pkg.sv */
// shared widths, bus addresses, response codes and types, imported by the bridge RTL and its testbench
package aes_bridge_pkg;

	// ------------------------------------------------------------
	// widths and sizes
	// ------------------------------------------------------------
	localparam int BYTE_W      = 8;                    // one key, plaintext or cipher byte
	localparam int BLOCK_BYTES = 16;                   // bytes per block, also depth of every fifo
	localparam int BUS_W       = 32;                   // bus address and data width
	localparam int PTR_W       = $clog2(BLOCK_BYTES);  // fifo pointer and byte counter width

	// ------------------------------------------------------------
	// basic types
	// ------------------------------------------------------------
	typedef logic [BYTE_W-1:0]             byte_t;     // one data byte
	typedef logic [BUS_W-1:0]              bus_word_t; // bus address or data
	typedef logic [1:0]                    bus_resp_t; // read response code
	typedef logic [PTR_W:0]                fifo_cnt_t; // occupancy, 0 up to 16
	typedef logic [BLOCK_BYTES*BYTE_W-1:0] block_t;    // full 128-bit engine state

	// ------------------------------------------------------------
	// bus map
	// ------------------------------------------------------------
	localparam bus_word_t FIFO_ADDR   = 32'h0000_0510; // byte writes in, cipher bytes out
	localparam bus_word_t STATUS_ADDR = 32'h0000_0514; // read only, bit 0 ready, bit 1 busy

	// read responses, same encoding as an axi slave
	localparam bus_resp_t RESP_OKAY   = 2'd0; // normal completion
	localparam bus_resp_t RESP_SLVERR = 2'd2; // data read with nothing waiting
	localparam bus_resp_t RESP_DECERR = 2'd3; // nothing mapped at that address

	// ------------------------------------------------------------
	// controller states
	// ------------------------------------------------------------
	typedef enum logic [2:0]
	{
		COLLECT_KEY, // key bytes go to the key fifo
		COLLECT_PT,  // plaintext bytes go to the plaintext fifo
		FEED,        // both input fifos stream into the engine
		WAIT_CORE,   // engine holds the block, no output yet
		DRAIN,       // engine emitting into the cipher fifo
		DONE         // block ready for the host to read
	} bridge_state_t;

endpackage

/* logic/byte_fifo.sv */
// 16-entry first-word-fall-through byte fifo, instanced for key, plaintext and cipher bytes
`timescale 1ns/1ps

module byte_fifo
(
	input  logic                  clk_main_a0,
	input  logic                  rst_main_n_sync,
	input  logic                  push,   // write din, legal only when not full
	input  logic                  pop,    // drop head entry, legal only when not empty
	input  aes_bridge_pkg::byte_t din,
	output aes_bridge_pkg::byte_t dout,   // always the head entry
	output logic                  full,
	output logic                  empty
);

	import aes_bridge_pkg::*;

	// ------------------------------------------------------------
	// storage and pointers
	// ------------------------------------------------------------
	byte_t            mem [BLOCK_BYTES]; // register array, no reset on payload
	logic [PTR_W-1:0] wr_ptr;            // next slot to fill
	logic [PTR_W-1:0] rd_ptr;            // head slot
	fifo_cnt_t        cnt;               // entries held

	// pointers wrap on their own at 16
	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			cnt    <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= rd_ptr + 1'b1;
			// count moves only when one side acts alone
			case ({push, pop})
				2'b10:   cnt <= cnt + 1'b1;
				2'b01:   cnt <= cnt - 1'b1;
				default: cnt <= cnt;
			endcase
		end
	end

	// data write
	always_ff @(posedge clk_main_a0)
	begin
		if (push)
			mem[wr_ptr] <= din;
	end

	// ------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------
	assign dout  = mem[rd_ptr]; // head visible without a read cycle
	assign full  = (cnt == fifo_cnt_t'(BLOCK_BYTES));
	assign empty = (cnt == '0);

	// producer and consumer both keep to the flags
	a_no_push_full: assert property (
		@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		push |-> !full
	) else $error("byte_fifo push while full");

	a_no_pop_empty: assert property (
		@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		pop |-> !empty
	) else $error("byte_fifo pop while empty");

endmodule

/* logic/add_round_key_core.sv */
// byte-serial add-round-key engine that loads 16 key xor plaintext bytes and then shifts them out in order
`timescale 1ns/1ps

module add_round_key_core
(
	input  logic                  clk_main_a0,
	input  logic                  rst_main_n_sync,
	input  logic                  in_valid,  // one byte pair this cycle
	input  aes_bridge_pkg::byte_t key_byte,
	input  aes_bridge_pkg::byte_t pt_byte,
	output logic                  out_valid, // one result byte this cycle
	output aes_bridge_pkg::byte_t out_byte
);

	import aes_bridge_pkg::*;

	// ------------------------------------------------------------
	// state
	// ------------------------------------------------------------
	block_t           blk;      // 128-bit state with the first byte on top
	logic [PTR_W-1:0] byte_cnt; // counts loads and then emits
	logic             emitting; // high for the 16 output cycles
	byte_t            mix_byte; // the round key addition itself

	assign mix_byte = key_byte ^ pt_byte;

	// phase control with one counter for both phases
	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			byte_cnt <= '0;
			emitting <= 1'b0;
		end
		else if (emitting)
		begin
			byte_cnt <= byte_cnt + 1'b1;
			if (byte_cnt == PTR_W'(BLOCK_BYTES - 1))
				emitting <= 1'b0; // last byte out so loading resumes
		end
		else if (in_valid)
		begin
			byte_cnt <= byte_cnt + 1'b1;
			// whole block held so emitting starts next cycle
			if (byte_cnt == PTR_W'(BLOCK_BYTES - 1))
				emitting <= 1'b1;
		end
	end

	// left shift register in both phases
	always_ff @(posedge clk_main_a0)
	begin
		if (emitting)
			blk <= {blk[$bits(block_t)-BYTE_W-1:0], byte_t'(0)};
		else if (in_valid)
			blk <= {blk[$bits(block_t)-BYTE_W-1:0], mix_byte}; // newest byte at bottom
	end

	// ------------------------------------------------------------
	// outputs
	// ------------------------------------------------------------
	assign out_valid = emitting;
	assign out_byte  = blk[$bits(block_t)-1 -: BYTE_W]; // oldest load first

	// the controller must not feed while a block is leaving
	a_no_load_in_emit: assert property (
		@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		in_valid |-> !emitting
	) else $error("add_round_key_core in_valid during emit phase");

endmodule

/* logic/bridge_ctrl.sv */
// bridge control fsm: routes host bytes into the input fifos, feeds the engine, gates cipher reads
`timescale 1ns/1ps

module bridge_ctrl
(
	input  logic                  clk_main_a0,
	input  logic                  rst_main_n_sync,
	input  logic                  wr_byte_valid, // host byte write this cycle
	input  aes_bridge_pkg::byte_t wr_byte,
	input  logic                  rd_data_req,   // host accepted a cipher byte read
	input  logic                  key_full,
	input  logic                  key_empty,
	input  logic                  pt_full,
	input  logic                  pt_empty,
	input  logic                  cipher_full,
	input  logic                  cipher_empty,
	output logic                  key_push,
	output logic                  pt_push,
	output aes_bridge_pkg::byte_t fifo_din,      // shared by both input fifos
	output logic                  key_pop,
	output logic                  pt_pop,
	output logic                  core_in_valid,
	output logic                  cipher_pop,
	output logic                  status_ready,  // status bit 0
	output logic                  status_busy    // status bit 1
);

	import aes_bridge_pkg::*;

	bridge_state_t    state;
	bridge_state_t    state_next;
	logic [PTR_W-1:0] feed_cnt;  // byte pairs handed to the engine
	logic             feed_last; // 16th pair goes out this cycle

	// ------------------------------------------------------------
	// write routing
	// ------------------------------------------------------------
	assign fifo_din = wr_byte;
	assign key_push = (state == COLLECT_KEY) && wr_byte_valid && !key_full;
	// a byte arriving while the key fifo just filled already belongs to plaintext
	assign pt_push  = wr_byte_valid && !pt_full &&
		((state == COLLECT_PT) || ((state == COLLECT_KEY) && key_full));

	// ------------------------------------------------------------
	// engine feed
	// ------------------------------------------------------------
	// each fifo pops on its own flag so a lost byte shows up as a mismatch
	assign key_pop       = (state == FEED) && !key_empty;
	assign pt_pop        = (state == FEED) && !pt_empty;
	assign core_in_valid = key_pop && pt_pop;
	assign feed_last     = core_in_valid && (feed_cnt == PTR_W'(BLOCK_BYTES - 1));

	// host reads only drain the cipher fifo once the block is complete
	assign cipher_pop   = (state == DONE) && rd_data_req && !cipher_empty;
	assign status_ready = (state == DONE);
	assign status_busy  = (state == FEED) || (state == WAIT_CORE) || (state == DRAIN);

	// next state
	always_comb
	begin
		state_next = state;
		case (state)
			COLLECT_KEY:
				if (key_full)
					state_next = COLLECT_PT;
			COLLECT_PT:
				if (pt_full)
					state_next = FEED;
			FEED:
				if (feed_last)
					state_next = WAIT_CORE; // leaves after exactly 16 cycles
			WAIT_CORE:
				if (!cipher_empty)
					state_next = DRAIN;     // first result byte landed
			DRAIN:
				if (cipher_full)
					state_next = DONE;
			DONE:
				if (cipher_empty)
					state_next = COLLECT_KEY; // host read every byte
			default:
				state_next = COLLECT_KEY;
		endcase
	end

	// state and feed counter registers
	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			state    <= COLLECT_KEY;
			feed_cnt <= '0;
		end
		else
		begin
			state <= state_next;
			if (core_in_valid)
				feed_cnt <= feed_cnt + 1'b1; // wraps to 0 after the 16th pair
		end
	end

	// key and plaintext stay in lockstep for the whole feed
	a_pop_lockstep: assert property (
		@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		key_pop == pt_pop
	) else $error("bridge_ctrl key and plaintext fifos out of step");

endmodule

/* logic/bus_port.sv */
// bus slave: decodes byte writes and runs the registered read channel for data and status
`timescale 1ns/1ps

module bus_port
(
	input  logic                      clk_main_a0,
	input  logic                      rst_main_n_sync,
	input  aes_bridge_pkg::bus_word_t wr_addr,
	input  logic                      wready,        // write offered this cycle
	input  aes_bridge_pkg::bus_word_t wdata,
	input  logic                      arvalid_q,     // read request
	input  aes_bridge_pkg::bus_word_t araddr_q,
	input  logic                      rready,
	input  logic                      status_ready,
	input  logic                      status_busy,
	input  logic                      cipher_empty,
	input  aes_bridge_pkg::byte_t     cipher_dout,   // cipher fifo head
	output logic                      wr_byte_valid,
	output aes_bridge_pkg::byte_t     wr_byte,
	output logic                      rd_data_req,   // pops one cipher byte
	output logic                      rvalid,
	output aes_bridge_pkg::bus_word_t rdata,
	output aes_bridge_pkg::bus_resp_t rresp
);

	import aes_bridge_pkg::*;

	logic rd_accept;    // new read taken this cycle
	logic rd_done;      // host took the current response
	logic data_waiting; // a finished block still has bytes

	// ------------------------------------------------------------
	// write decode
	// ------------------------------------------------------------
	assign wr_byte_valid = wready && (wr_addr == FIFO_ADDR);
	assign wr_byte       = wdata[BYTE_W-1:0]; // upper bytes ignored

	// ------------------------------------------------------------
	// read channel
	// ------------------------------------------------------------
	assign rd_accept    = arvalid_q && !rvalid; // one outstanding read at a time
	assign rd_done      = rvalid && rready;
	assign data_waiting = status_ready && !cipher_empty;
	assign rd_data_req  = rd_accept && (araddr_q == FIFO_ADDR) && data_waiting;

	// rvalid, up the cycle after accept and down after the handshake
	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
			rvalid <= 1'b0;
		else if (rd_accept)
			rvalid <= 1'b1;
		else if (rd_done)
			rvalid <= 1'b0;
	end

	// response payload, only loaded on accept so it holds under back-pressure
	always_ff @(posedge clk_main_a0)
	begin
		if (rd_accept)
		begin
			if (araddr_q == FIFO_ADDR)
			begin
				if (data_waiting)
				begin
					rdata <= bus_word_t'(cipher_dout); // zero extended
					rresp <= RESP_OKAY;
				end
				else
				begin
					rdata <= '0;                       // nothing to hand out
					rresp <= RESP_SLVERR;
				end
			end
			else if (araddr_q == STATUS_ADDR)
			begin
				rdata <= {{(BUS_W-2){1'b0}}, status_busy, status_ready};
				rresp <= RESP_OKAY;
			end
			else
			begin
				rdata <= '0;                           // unmapped
				rresp <= RESP_DECERR;
			end
		end
	end

	// held response must not move until the host takes it
	a_rd_stable: assert property (
		@(posedge clk_main_a0) disable iff (!rst_main_n_sync)
		(rvalid && !rready) |=> (rvalid && $stable(rdata) && $stable(rresp))
	) else $error("bus_port read response changed under back-pressure");

endmodule

/* logic/aes_bridge.sv */
// top level of the bridge: bus port, control fsm, key/plaintext/cipher fifos and the engine
`timescale 1ns/1ps

module aes_bridge
(
	input  logic                      clk_main_a0,
	input  logic                      rst_main_n_sync,
	input  aes_bridge_pkg::bus_word_t wr_addr,
	input  logic                      wready,
	input  aes_bridge_pkg::bus_word_t wdata,
	input  logic                      arvalid_q,
	input  aes_bridge_pkg::bus_word_t araddr_q,
	input  logic                      rready,
	output logic                      rvalid,
	output aes_bridge_pkg::bus_word_t rdata,
	output aes_bridge_pkg::bus_resp_t rresp
);

	import aes_bridge_pkg::*;

	// ------------------------------------------------------------
	// internal nets
	// ------------------------------------------------------------
	logic  wr_byte_valid, rd_data_req;            // bus port to control
	byte_t wr_byte, fifo_din;
	logic  status_ready, status_busy;
	logic  key_push, key_pop, key_full, key_empty; // key fifo
	logic  pt_push, pt_pop, pt_full, pt_empty;     // plaintext fifo
	byte_t key_dout, pt_dout;
	logic  cipher_pop, cipher_full, cipher_empty;  // cipher fifo
	byte_t cipher_dout;
	logic  core_in_valid, core_out_valid;          // engine handshake
	byte_t core_out_byte;

	bus_port bus_port_i (
		.clk_main_a0, .rst_main_n_sync, .wr_addr, .wready, .wdata,
		.arvalid_q, .araddr_q, .rready, .status_ready, .status_busy,
		.cipher_empty, .cipher_dout, .wr_byte_valid, .wr_byte,
		.rd_data_req, .rvalid, .rdata, .rresp
	);

	bridge_ctrl bridge_ctrl_i (
		.clk_main_a0, .rst_main_n_sync, .wr_byte_valid, .wr_byte, .rd_data_req,
		.key_full, .key_empty, .pt_full, .pt_empty, .cipher_full, .cipher_empty,
		.key_push, .pt_push, .fifo_din, .key_pop, .pt_pop, .core_in_valid,
		.cipher_pop, .status_ready, .status_busy
	);

	// input fifos share the write byte, control picks which one pushes
	byte_fifo key_fifo_i (
		.clk_main_a0, .rst_main_n_sync, .push(key_push), .pop(key_pop),
		.din(fifo_din), .dout(key_dout), .full(key_full), .empty(key_empty)
	);

	byte_fifo pt_fifo_i (
		.clk_main_a0, .rst_main_n_sync, .push(pt_push), .pop(pt_pop),
		.din(fifo_din), .dout(pt_dout), .full(pt_full), .empty(pt_empty)
	);

	// engine output pushes the cipher fifo directly
	add_round_key_core add_round_key_core_i (
		.clk_main_a0, .rst_main_n_sync, .in_valid(core_in_valid),
		.key_byte(key_dout), .pt_byte(pt_dout),
		.out_valid(core_out_valid), .out_byte(core_out_byte)
	);

	byte_fifo cipher_fifo_i (
		.clk_main_a0, .rst_main_n_sync, .push(core_out_valid), .pop(cipher_pop),
		.din(core_out_byte), .dout(cipher_dout), .full(cipher_full), .empty(cipher_empty)
	);

endmodule

/* tests/aes_bridge_tb.sv */
// self-checking testbench that writes key and plaintext blocks to the bridge, polls status and reads the results
`timescale 1ns/1ps

module aes_bridge_tb;

	import aes_bridge_pkg::*;

	localparam int        NUM_ROWS   = 4;             // three fixed rows plus one random row
	localparam int        WAIT_LIMIT = 20;            // cycles allowed for one read handshake
	localparam int        POLL_LIMIT = 50;            // status reads allowed per block
	localparam bus_word_t BAD_ADDR   = 32'h0000_0518; // unmapped word next to the status word

	logic      clk_main_a0;
	logic      rst_main_n_sync;
	bus_word_t wr_addr;
	logic      wready;
	bus_word_t wdata;
	logic      arvalid_q;
	bus_word_t araddr_q;
	logic      rready;
	logic      rvalid;
	bus_word_t rdata;
	bus_resp_t rresp;

	block_t key_tbl [NUM_ROWS];
	block_t pt_tbl  [NUM_ROWS];
	block_t exp_tbl [NUM_ROWS];
	int     err_cnt;
	int     check_cnt;
	event   run_abort; // raised by a timeout

	aes_bridge dut_i (
		.clk_main_a0, .rst_main_n_sync, .wr_addr, .wready, .wdata,
		.arvalid_q, .araddr_q, .rready, .rvalid, .rdata, .rresp
	);

	// 40 ns clock
	initial
	begin
		clk_main_a0 = 1'b0;
		forever #20 clk_main_a0 = ~clk_main_a0;
	end

	// ------------------------------------------------------------
	// helpers
	// ------------------------------------------------------------
	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223; // numerical recipes constants
	endfunction

	// byte 0 is the most significant byte and the first one written
	function automatic byte_t get_byte(input block_t b, input int i);
		return b[$bits(block_t)-1-BYTE_W*i -: BYTE_W];
	endfunction

	task automatic check_value(input bus_word_t got, input bus_word_t exp, input string msg);
		check_cnt++;
		if (got !== exp)
		begin
			err_cnt++;
			$display("Error at %0d ns: %s, got %h expected %h", $time, msg, got, exp);
		end
	endtask

	task automatic timeout_abort(input string what);
		err_cnt++;
		$display("Timeout at %0d ns: %s", $time, what);
		-> run_abort;
		@(negedge clk_main_a0); // hold here while the run is stopped
	endtask

	// one write offered for a single cycle
	task automatic write_word(input bus_word_t addr, input bus_word_t data);
		@(posedge clk_main_a0);
		wready  <= 1'b1;
		wr_addr <= addr;
		wdata   <= data;
		@(posedge clk_main_a0);
		wready  <= 1'b0;
	endtask

	// upper data bytes carry junk that the bridge drops
	task automatic write_block(input block_t key, input block_t pt, input bit interleave);
		int i;
		for (i = 0; i < BLOCK_BYTES; i++)
		begin
			write_word(FIFO_ADDR, {24'h5a5a5a, get_byte(key, i)});
			if (interleave)
				write_word(BAD_ADDR, {24'h0, ~get_byte(key, i)}); // must not land anywhere
		end
		for (i = 0; i < BLOCK_BYTES; i++)
		begin
			write_word(FIFO_ADDR, {24'h5a5a5a, get_byte(pt, i)});
			if (interleave)
				write_word(BAD_ADDR, {24'h0, ~get_byte(pt, i)});
		end
	endtask

	// read with optional back-pressure where stall counts the cycles rready stays low
	task automatic bus_read(input bus_word_t addr, input int stall,
		output bus_word_t data, output bus_resp_t resp);
		int waited;
		int k;
		@(posedge clk_main_a0);
		arvalid_q <= 1'b1;
		araddr_q  <= addr;
		rready    <= (stall == 0);
		waited = 0;
		@(negedge clk_main_a0);
		while (!rvalid)
		begin
			if (waited == WAIT_LIMIT)
				timeout_abort("read request was never answered");
			waited++;
			@(negedge clk_main_a0);
		end
		data = rdata; // taken mid cycle
		resp = rresp;
		@(posedge clk_main_a0);
		arvalid_q <= 1'b0; // one read only
		for (k = 0; k < stall; k++)
		begin
			@(negedge clk_main_a0);
			check_value(bus_word_t'(rvalid), 32'd1, "rvalid dropped under back-pressure");
			check_value(rdata, data, "rdata moved under back-pressure");
		end
		if (stall > 0)
		begin
			@(posedge clk_main_a0);
			rready <= 1'b1;
		end
		waited = 0;
		@(negedge clk_main_a0);
		while (rvalid)
		begin
			if (waited == WAIT_LIMIT)
				timeout_abort("read response never completed");
			waited++;
			@(negedge clk_main_a0);
		end
	endtask

	task automatic wait_block_ready();
		bus_word_t data;
		bus_resp_t resp;
		int        polls;
		polls = 0;
		data  = '0;
		while (data[0] !== 1'b1)
		begin
			if (polls == POLL_LIMIT)
				timeout_abort("status never showed a finished block");
			bus_read(STATUS_ADDR, 0, data, resp);
			polls++;
			if (data[0] !== 1'b1)
				check_value(data, 32'd2, "status while the block is processed"); // busy only
		end
		check_value(data, 32'd1, "status with a finished block");
		check_value(bus_word_t'(resp), bus_word_t'(RESP_OKAY), "status read response");
	endtask

	// ------------------------------------------------------------
	// stimulus table
	// ------------------------------------------------------------
	task automatic load_table();
		logic [31:0] seed;
		int          i;
		byte_t       kb;
		byte_t       pb;
		key_tbl[0] = 128'h000102030405060708090a0b0c0d0e0f;
		pt_tbl[0]  = 128'h00112233445566778899aabbccddeeff;
		exp_tbl[0] = 128'h00102030405060708090a0b0c0d0e0f0;
		key_tbl[1] = 128'hffffffffffffffffffffffffffffffff;
		pt_tbl[1]  = 128'h0123456789abcdeffedcba9876543210;
		exp_tbl[1] = 128'hfedcba98765432100123456789abcdef;
		key_tbl[2] = 128'h2b7e151628aed2a6abf7158809cf4f3c; // fips-197 example key
		pt_tbl[2]  = 128'h3243f6a8885a308d313198a2e0370734;
		exp_tbl[2] = 128'h193de3bea0f4e22b9ac68d2ae9f84808; // state after first add round key
		seed = 32'h824b_0f73;
		for (i = 0; i < BLOCK_BYTES; i++)
		begin
			seed = lcg_next(seed);
			kb   = seed[31:24]; // top bits mix best
			seed = lcg_next(seed);
			pb   = seed[31:24];
			key_tbl[3][$bits(block_t)-1-BYTE_W*i -: BYTE_W] = kb;
			pt_tbl[3][$bits(block_t)-1-BYTE_W*i -: BYTE_W]  = pb;
			exp_tbl[3][$bits(block_t)-1-BYTE_W*i -: BYTE_W] = kb ^ pb;
		end
	endtask

	// a timeout ends the run here
	initial
	begin
		@(run_abort);
		$display("run stopped: %0d checks, %0d errors", check_cnt, err_cnt);
		$display("FAIL: see errors above");
		$finish;
	end

	// ------------------------------------------------------------
	// main sequence
	// ------------------------------------------------------------
	initial
	begin
		int        row;
		int        i;
		bus_word_t data;
		bus_resp_t resp;
		rst_main_n_sync = 1'b0;
		wr_addr         = '0;
		wready          = 1'b0;
		wdata           = '0;
		arvalid_q       = 1'b0;
		araddr_q        = '0;
		rready          = 1'b1;
		err_cnt         = 0;
		check_cnt       = 0;
		load_table();
		repeat (4) @(posedge clk_main_a0);
		rst_main_n_sync <= 1'b1;

		// idle bridge after reset
		@(negedge clk_main_a0);
		check_value(bus_word_t'(rvalid), 32'd0, "rvalid after reset");
		bus_read(STATUS_ADDR, 0, data, resp);
		check_value(data, 32'd0, "status after reset");
		check_value(bus_word_t'(resp), bus_word_t'(RESP_OKAY), "status resp after reset");
		bus_read(FIFO_ADDR, 0, data, resp);
		check_value(data, 32'd0, "empty data read");
		check_value(bus_word_t'(resp), bus_word_t'(RESP_SLVERR), "empty data read resp");
		bus_read(32'h0000_0000, 0, data, resp);
		check_value(data, 32'd0, "unmapped read data");
		check_value(bus_word_t'(resp), bus_word_t'(RESP_DECERR), "unmapped read resp");

		for (row = 0; row < NUM_ROWS; row++)
		begin
			write_block(key_tbl[row], pt_tbl[row], row == 1); // row 1 interleaves stray writes
			if (row == 0 || row == 2)
				repeat (4) write_word(FIFO_ADDR, 32'h0000_00ee); // dropped while busy
			wait_block_ready();
			if (row == 0 || row == 2)
				repeat (3) write_word(FIFO_ADDR, 32'h0000_0077); // dropped while the block waits
			for (i = 0; i < BLOCK_BYTES; i++)
			begin
				bus_read(FIFO_ADDR, (i % 4 == 1) ? 5 : 0, data, resp); // some reads stalled
				check_value(data, bus_word_t'(get_byte(exp_tbl[row], i)),
					$sformatf("row %0d byte %0d data", row, i));
				check_value(bus_word_t'(resp), bus_word_t'(RESP_OKAY),
					$sformatf("row %0d byte %0d resp", row, i));
			end
			bus_read(STATUS_ADDR, 0, data, resp);
			check_value(data, 32'd0, $sformatf("row %0d status after drain", row));
			bus_read(FIFO_ADDR, 0, data, resp);
			check_value(data, 32'd0, $sformatf("row %0d data read after drain", row));
			check_value(bus_word_t'(resp), bus_word_t'(RESP_SLVERR),
				$sformatf("row %0d resp after drain", row));
			if (row == 1)
			begin
				bus_read(BAD_ADDR, 0, data, resp);
				check_value(data, 32'd0, "bad address read data");
				check_value(bus_word_t'(resp), bus_word_t'(RESP_DECERR), "bad address resp");
			end
		end

		$display("tests done: %0d checks, %0d errors", check_cnt, err_cnt);
		if (err_cnt == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

/* aes_bridge.f */
logic/aes_bridge_pkg.sv
logic/byte_fifo.sv
logic/add_round_key_core.sv
logic/bridge_ctrl.sv
logic/bus_port.sv
logic/aes_bridge.sv
tests/aes_bridge_tb.sv
